//--- hw/burst_rx_consts.svh
`ifndef BURST_RX_CONSTS_SVH
`define BURST_RX_CONSTS_SVH

// ----------------------------------------------------------------------
// line word format
// ----------------------------------------------------------------------

// width of one recovered line word, also the payload word width
`define BURST_WORD_W 32

// ----------------------------------------------------------------------
// frame sync patterns
// ----------------------------------------------------------------------

// preamble, repeated at burst start, checked with error tolerance
`define BURST_PREAMBLE 32'h05560556

// most mismatching bits that still count as a preamble hit
`define BURST_PREAMBLE_MAX_ERR 5

`define BURST_DELIMITER 32'hB3A5_0F1E // exact match, any of 32 offsets
`define BURST_TAIL 32'hFACE_0DD5 // exact match, locked offset only

// ----------------------------------------------------------------------
// sizes
// ----------------------------------------------------------------------

// words searched for the delimiter after sop before giving up
`define BURST_HUNT_LIMIT 16

`define BURST_FIFO_DEPTH 16 // output buffer entries

`endif

//--- hw/burst_rx_pkg.sv
`default_nettype none

`include "burst_rx_consts.svh"

package burst_rx_pkg;

  // one line or payload word, msb is first on the wire
  typedef logic [`BURST_WORD_W-1:0] word_t;

  typedef logic [$clog2(`BURST_WORD_W)-1:0] offset_t; // bit offset 0..31

  // mismatch count, wide enough for all 32 bits wrong
  typedef logic [$clog2(`BURST_WORD_W+1)-1:0] err_cnt_t;

  // aligner states
  typedef enum logic [1:0] {
    IDLE    = 2'd0, // waiting for sop
    HUNT    = 2'd1, // searching delimiter
    PAYLOAD = 2'd2  // offset locked, forwarding words
  } align_state_t;

endpackage

`default_nettype wire

//--- hw/burst_word_if.sv
`timescale 1ns/100ps
`default_nettype none

// aligned payload words, aligner to output fifo
// no ready here, the line side cannot be stalled
interface burst_word_if;
  import burst_rx_pkg::*;

  logic  valid;    // one cycle strobe per word
  word_t data;     // realigned payload word
  logic  last;     // final word of the burst
  logic  overflow; // sticky, word dropped on full fifo

  // aligner side
  modport src (
    output valid,
    output data,
    output last,
    input  overflow
  );

  // fifo side
  modport dst (
    input  valid,
    input  data,
    input  last,
    output overflow
  );

endinterface

`default_nettype wire

//--- hw/preamble_detector.sv
`timescale 1ns/100ps
`default_nettype none

`include "burst_rx_consts.svh"

module preamble_detector (
  input  logic                axis_aclk_gt_rx_usrclk,
  input  logic                arst_n,
  input  logic                rx_active,
  input  burst_rx_pkg::word_t rx_data,
  output logic                sop
);
  import burst_rx_pkg::*;

  localparam word_t    PREAMBLE = `BURST_PREAMBLE;
  localparam err_cnt_t MAX_ERR  = `BURST_PREAMBLE_MAX_ERR;

  word_t    diff_bits; // 1 where rx word and preamble disagree
  err_cnt_t err_cnt;   // number of disagreeing bits
  logic     match_now; // this word looks like a preamble
  logic     match_q;   // registered match flag
  logic     match_d;   // flag one cycle older, for edge detect

  // ----------------------------------------------------------------------
  // correlator
  // ----------------------------------------------------------------------

  assign diff_bits = rx_data ^ PREAMBLE;

  // population count of the mismatch vector
  always_comb begin
    err_cnt = '0;
    for (int i = 0; i < `BURST_WORD_W; i++) begin
      err_cnt = err_cnt + err_cnt_t'(diff_bits[i]);
    end
  end

  // only words sampled while the receiver is active can hit
  assign match_now = rx_active && (err_cnt <= MAX_ERR);

  // ----------------------------------------------------------------------
  // match flag and rising edge pulse
  // ----------------------------------------------------------------------

  // a run of preamble words keeps match_q high, so only the
  // first one of the run produces a pulse
  always_ff @(posedge axis_aclk_gt_rx_usrclk or negedge arst_n) begin
    if (!arst_n) begin
      match_q <= 1'b0;
      match_d <= 1'b0;
      sop     <= 1'b0;
    end else begin
      match_q <= match_now;            // 1 cycle after the word
      match_d <= match_q;
      sop     <= match_q && !match_d;  // 2 cycles after the word
    end
  end

endmodule

`default_nettype wire

//--- hw/delimiter_aligner.sv
`timescale 1ns/100ps
`default_nettype none

`include "burst_rx_consts.svh"

module delimiter_aligner (
  input  logic                axis_aclk_gt_rx_usrclk,
  input  logic                arst_n,
  input  logic                rx_active,
  input  burst_rx_pkg::word_t rx_data,
  input  logic                sop,
  burst_word_if.src           words
);
  import burst_rx_pkg::*;

  localparam int    W          = `BURST_WORD_W;
  localparam int    HUNT_CNT_W = $clog2(`BURST_HUNT_LIMIT + 1);
  localparam word_t DELIMITER  = `BURST_DELIMITER;
  localparam word_t TAIL       = `BURST_TAIL;
  localparam logic [HUNT_CNT_W-1:0] HUNT_LAST = HUNT_CNT_W'(`BURST_HUNT_LIMIT - 1);

  align_state_t          state;
  word_t                 prev_word;  // previous sampled line word
  logic [2*W-1:0]        window;     // prev word then current word, msb first
  logic                  delim_hit;  // delimiter found at some offset
  offset_t               delim_off;  // lowest offset that matched
  offset_t               lock_off;   // offset held for the burst
  word_t                 aligned;    // current word realigned at lock_off
  logic [HUNT_CNT_W-1:0] hunt_cnt;   // words searched so far
  word_t                 hold_data;  // one word held back for the last flag
  logic                  hold_vld;
  logic                  in_payload;
  logic                  tail_seen;  // frame tail at the locked offset
  logic                  capture;    // aligned word goes into the holder
  logic                  emit;       // held word goes out this cycle
  logic                  emit_last;  // and it closes the burst

  // ----------------------------------------------------------------------
  // bit window and delimiter search
  // ----------------------------------------------------------------------

  // offset k takes the last k bits of prev and first 32-k bits of current
  assign window  = {prev_word, rx_data};
  assign aligned = window[lock_off +: W];

  // walk from high to low offset so the lowest match wins
  always_comb begin
    delim_hit = 1'b0;
    delim_off = '0;
    for (int k = W - 1; k >= 0; k--) begin
      if (window[k +: W] == DELIMITER) begin
        delim_hit = 1'b1;
        delim_off = offset_t'(k);
      end
    end
  end

  // ----------------------------------------------------------------------
  // payload decode
  // ----------------------------------------------------------------------

  assign in_payload = (state == PAYLOAD);
  assign tail_seen  = in_payload && rx_active && (aligned == TAIL);
  assign capture    = in_payload && rx_active && !tail_seen;
  assign emit       = in_payload && hold_vld; // every payload cycle moves the holder
  assign emit_last  = tail_seen || !rx_active; // tail or receiver loss ends it

  // ----------------------------------------------------------------------
  // state machine
  // ----------------------------------------------------------------------

  always_ff @(posedge axis_aclk_gt_rx_usrclk or negedge arst_n) begin
    if (!arst_n) begin
      state       <= IDLE;
      lock_off    <= '0;
      hunt_cnt    <= '0;
      hold_vld    <= 1'b0;
      words.valid <= 1'b0;
      words.last  <= 1'b0;
    end else begin
      hold_vld    <= capture;          // tail and loss both empty the holder
      words.valid <= emit;
      words.last  <= emit && emit_last;
      case (state)
        IDLE: begin
          if (sop) begin
            state    <= HUNT;
            hunt_cnt <= '0;
          end
        end
        HUNT: begin
          if (!rx_active) begin
            state <= IDLE;             // burst gone before the delimiter
          end else if (delim_hit) begin
            state    <= PAYLOAD;
            lock_off <= delim_off;
          end else if (hunt_cnt == HUNT_LAST) begin
            state <= IDLE;             // give up, nothing emitted
          end else begin
            hunt_cnt <= hunt_cnt + 1'b1;
          end
        end
        PAYLOAD: begin
          if (emit_last) state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // payload registers
  always_ff @(posedge axis_aclk_gt_rx_usrclk) begin
    if (rx_active) prev_word <= rx_data; // only sampled words enter the window
    if (capture) hold_data <= aligned;
    if (emit) words.data <= hold_data;
  end

endmodule

`default_nettype wire

//--- hw/rx_stream_fifo.sv
`timescale 1ns/100ps
`default_nettype none

`include "burst_rx_consts.svh"

module rx_stream_fifo (
  input  logic                axis_aclk_gt_rx_usrclk,
  input  logic                arst_n,
  burst_word_if.dst           words,
  output burst_rx_pkg::word_t m_axis_tdata,
  output logic                m_axis_tlast,
  output logic                m_axis_tvalid,
  input  logic                m_axis_tready
);
  import burst_rx_pkg::*;

  localparam int DEPTH = `BURST_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);

  word_t            data_mem [DEPTH]; // payload entries
  logic             last_mem [DEPTH]; // matching last flags
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;            // occupancy
  logic             full;
  logic             rd_en;            // stream transfer this cycle
  logic             wr_en;            // incoming word accepted
  logic             overflow_q;

  // ----------------------------------------------------------------------
  // flags
  // ----------------------------------------------------------------------

  assign full  = (count == CNT_W'(DEPTH));
  assign rd_en = m_axis_tvalid && m_axis_tready;
  // a read in the same cycle frees a slot, so full plus read still writes
  assign wr_en = words.valid && (!full || rd_en);

  // ----------------------------------------------------------------------
  // storage
  // ----------------------------------------------------------------------

  always_ff @(posedge axis_aclk_gt_rx_usrclk) begin
    if (wr_en) begin
      data_mem[wr_ptr] <= words.data;
      last_mem[wr_ptr] <= words.last;
    end
  end

  // ----------------------------------------------------------------------
  // pointers, count, overflow
  // ----------------------------------------------------------------------

  always_ff @(posedge axis_aclk_gt_rx_usrclk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      overflow_q <= 1'b0;
    end else begin
      if (wr_en) wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
      if (rd_en) rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;       // none, or one in and one out
      endcase
      if (words.valid && !wr_en) overflow_q <= 1'b1; // dropped, sticky until reset
    end
  end

  // stream side reads straight from the head entry
  assign m_axis_tvalid  = (count != '0);
  assign m_axis_tdata   = data_mem[rd_ptr];
  assign m_axis_tlast   = m_axis_tvalid && last_mem[rd_ptr]; // empty entries stay quiet
  assign words.overflow = overflow_q;

endmodule

`default_nettype wire

//--- hw/burst_rx_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "burst_rx_consts.svh"

module burst_rx_top (
  input  logic                     axis_aclk_gt_rx_usrclk,
  input  logic                     arst_n,
  // recovered line side
  input  logic                     rx_active,
  input  logic [`BURST_WORD_W-1:0] rx_data,
  // status
  output logic                     sop_detected,
  output logic                     overflow,
  // user stream
  output logic [`BURST_WORD_W-1:0] m_axis_tdata,
  output logic                     m_axis_tlast,
  output logic                     m_axis_tvalid,
  input  logic                     m_axis_tready
);

  // aligned words, aligner to fifo
  burst_word_if u_words ();

  // ----------------------------------------------------------------------
  // frame sync
  // ----------------------------------------------------------------------

  preamble_detector u_preamble_detector (
    .axis_aclk_gt_rx_usrclk (axis_aclk_gt_rx_usrclk),
    .arst_n                 (arst_n),
    .rx_active              (rx_active),
    .rx_data                (rx_data),
    .sop                    (sop_detected) // also starts the delimiter hunt
  );

  delimiter_aligner u_delimiter_aligner (
    .axis_aclk_gt_rx_usrclk (axis_aclk_gt_rx_usrclk),
    .arst_n                 (arst_n),
    .rx_active              (rx_active),
    .rx_data                (rx_data),
    .sop                    (sop_detected),
    .words                  (u_words.src)
  );

  // ----------------------------------------------------------------------
  // output buffer
  // ----------------------------------------------------------------------

  rx_stream_fifo u_rx_stream_fifo (
    .axis_aclk_gt_rx_usrclk (axis_aclk_gt_rx_usrclk),
    .arst_n                 (arst_n),
    .words                  (u_words.dst),
    .m_axis_tdata           (m_axis_tdata),
    .m_axis_tlast           (m_axis_tlast),
    .m_axis_tvalid          (m_axis_tvalid),
    .m_axis_tready          (m_axis_tready)
  );

  assign overflow = u_words.overflow; // sticky drop flag from the fifo

endmodule

`default_nettype wire

//--- tests/burst_rx_checker.sv
`timescale 1ns/100ps
`default_nettype none

`include "burst_rx_consts.svh"

module burst_rx_checker (
  input  logic                     axis_aclk_gt_rx_usrclk,
  input  logic                     arst_n,
  input  logic                     sop_detected,
  input  logic                     overflow,
  input  logic [`BURST_WORD_W-1:0] m_axis_tdata,
  input  logic                     m_axis_tlast,
  input  logic                     m_axis_tvalid,
  input  logic                     m_axis_tready
);
  import burst_rx_pkg::*;

  word_t exp_data_q [$];  // words still owed by the DUT
  logic  exp_last_q [$];  // their last flags
  word_t exp_data;
  logic  exp_last;
  string test_name  = "none";
  int    sop_cnt    = 0;  // sop pulses in the current test
  int    word_cnt   = 0;  // accepted stream words in the current test
  int    data_errs  = 0;
  int    count_errs = 0;

  // ----------------------------------------------------------------------
  // control from the testbench
  // ----------------------------------------------------------------------

  task automatic start_test(input string name);
    test_name = name;
    sop_cnt   = 0;
    word_cnt  = 0;
    exp_data_q.delete();
    exp_last_q.delete();
  endtask

  task automatic expect_word(input word_t data, input logic last);
    exp_data_q.push_back(data);
    exp_last_q.push_back(last);
  endtask

  function automatic int pending();
    return exp_data_q.size();
  endfunction

  task automatic compare_int(input string what, input int exp, input int act);
    if (exp != act) begin
      count_errs++;
      $display("ERROR %s %s: expected %0d, actual %0d", test_name, what, exp, act);
    end
  endtask

  // per burst totals, run once the stream has drained
  task automatic end_test(input int exp_sop, input int exp_words, input int exp_ovf);
    compare_int("sop pulses", exp_sop, sop_cnt);
    compare_int("stream words", exp_words, word_cnt);
    compare_int("overflow", exp_ovf, int'(overflow));
  endtask

  // outputs that must sit low right after reset
  task automatic check_quiet(input string name);
    test_name = name;
    compare_int("tvalid", 0, int'(m_axis_tvalid));
    compare_int("sop_detected", 0, int'(sop_detected));
    compare_int("overflow", 0, int'(overflow));
  endtask

  task automatic report(input int timeouts);
    $display("errors: data %0d, counts %0d, timeouts %0d", data_errs, count_errs, timeouts);
  endtask

  // ----------------------------------------------------------------------
  // monitor, sampled mid cycle where inputs and outputs are settled
  // ----------------------------------------------------------------------

  always @(negedge axis_aclk_gt_rx_usrclk) begin
    if (arst_n) begin
      if (sop_detected) sop_cnt++;
      if (m_axis_tvalid && m_axis_tready) begin // transfer at the coming edge
        word_cnt++;
        if (exp_data_q.size() == 0) begin
          data_errs++;
          $display("test %s: stream word %h came out but none was expected",
                   test_name, m_axis_tdata);
        end else begin
          exp_data = exp_data_q.pop_front();
          exp_last = exp_last_q.pop_front();
          if (m_axis_tdata !== exp_data) begin
            data_errs++;
            $display("ERROR %s tdata: expected %h, actual %h", test_name, exp_data, m_axis_tdata);
          end
          if (m_axis_tlast !== exp_last) begin
            data_errs++;
            $display("ERROR %s tlast: expected %b, actual %b", test_name, exp_last, m_axis_tlast);
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- tests/tb_burst_rx.sv
`timescale 1ns/100ps
`default_nettype none

`include "burst_rx_consts.svh"

module tb_burst_rx;
  import burst_rx_pkg::*;

  localparam int W           = `BURST_WORD_W;
  localparam int NUM_TESTS   = 12;
  localparam int IDLE_WORDS  = 24;  // longer than a failed delimiter hunt
  localparam int DRAIN_LIMIT = 400; // cycles allowed for the stream to empty

  typedef struct {
    string name;
    int    n_pre;      // preamble words
    int    pre_err;    // flipped bits per preamble word
    int    offset;     // delimiter bit offset
    int    has_delim;  // 0 sends the delimiter only after the hunt gave up
    int    len;        // payload words
    int    ready_mode; // 0 high, 1 random, 2 low while streaming
    int    cut;        // payload words before rx_active drops, 0 keeps it
    int    exp_sop;
    int    exp_words;
    int    exp_ovf;
  } entry_t;

  logic           axis_aclk_gt_rx_usrclk;
  logic           arst_n;
  logic           rx_active;
  logic [W-1:0]   rx_data;
  logic           sop_detected;
  logic           overflow;
  logic [W-1:0]   m_axis_tdata;
  logic           m_axis_tlast;
  logic           m_axis_tvalid;
  logic           m_axis_tready;

  entry_t         tbl [NUM_TESTS];
  logic [W:0]     line_q [$];      // {rx_active, rx_data} per cycle
  word_t          payload [$];
  integer         seed = 32'hed50;
  int             timeouts = 0;

  burst_rx_top u_dut (
    .axis_aclk_gt_rx_usrclk (axis_aclk_gt_rx_usrclk),
    .arst_n                 (arst_n),
    .rx_active              (rx_active),
    .rx_data                (rx_data),
    .sop_detected           (sop_detected),
    .overflow               (overflow),
    .m_axis_tdata           (m_axis_tdata),
    .m_axis_tlast           (m_axis_tlast),
    .m_axis_tvalid          (m_axis_tvalid),
    .m_axis_tready          (m_axis_tready)
  );

  burst_rx_checker u_chk (
    .axis_aclk_gt_rx_usrclk (axis_aclk_gt_rx_usrclk),
    .arst_n                 (arst_n),
    .sop_detected           (sop_detected),
    .overflow               (overflow),
    .m_axis_tdata           (m_axis_tdata),
    .m_axis_tlast           (m_axis_tlast),
    .m_axis_tvalid          (m_axis_tvalid),
    .m_axis_tready          (m_axis_tready)
  );

  initial begin
    axis_aclk_gt_rx_usrclk = 1'b0;
    forever #20 axis_aclk_gt_rx_usrclk = ~axis_aclk_gt_rx_usrclk; // 40 ns
  end

  // ----------------------------------------------------------------------
  // stimulus table
  // ----------------------------------------------------------------------

  task automatic load_table();
    //          name             pre err off dlm len rdy cut sop wrd ovf
    tbl[0]  = '{"aligned_err0",  4,  0,  0,  1,  8,  0,  0,  1,  8,  0};
    tbl[1]  = '{"pre_err3",      4,  3,  0,  1,  4,  0,  0,  1,  4,  0};
    tbl[2]  = '{"pre_err5",      4,  5,  3,  1,  4,  0,  0,  1,  4,  0};
    tbl[3]  = '{"pre_err6",      4,  6,  0,  1,  4,  0,  0,  0,  0,  0}; // too noisy
    tbl[4]  = '{"offset7",       4,  0,  7,  1,  8,  0,  0,  1,  8,  0};
    tbl[5]  = '{"offset19",      4,  2, 19,  1,  8,  0,  0,  1,  8,  0};
    tbl[6]  = '{"offset31",      4,  0, 31,  1,  8,  0,  0,  1,  8,  0};
    tbl[7]  = '{"ready_random",  4,  0, 11,  1, 12,  1,  0,  1, 12,  0};
    tbl[8]  = '{"no_delimiter",  4,  0,  0,  0,  6,  0,  0,  1,  0,  0};
    tbl[9]  = '{"after_miss",    4,  0,  5,  1,  6,  0,  0,  1,  6,  0};
    tbl[10] = '{"rx_loss",       4,  0,  9,  1, 10,  0,  4,  1,  4,  0};
    tbl[11] = '{"overflow",      4,  0, 13,  1, 24,  2,  0,  1, 16,  1}; // sticky, keep last
  endtask

  // ----------------------------------------------------------------------
  // bitstream builder
  // ----------------------------------------------------------------------

  function automatic bit near_preamble(input word_t w);
    return $countones(w ^ `BURST_PREAMBLE) <= `BURST_PREAMBLE_MAX_ERR;
  endfunction

  function automatic word_t random_payload();
    word_t w;
    do w = $random(seed); while (w == `BURST_TAIL || near_preamble(w));
    return w;
  endfunction

  function automatic word_t error_mask(input int n_err);
    word_t mask;
    int    idx;
    mask = '0;
    while ($countones(mask) < n_err) begin // distinct bit positions
      idx = $unsigned($random(seed)) % W;
      mask[idx] = 1'b1;
    end
    return mask;
  endfunction

  task automatic build_stream(input entry_t e);
    word_t        aligned_q [$]; // words as seen at the locked offset
    word_t        lines [$];     // same words shifted onto the line
    logic [2*W-1:0] pair;
    int           n_fill;        // zero words ahead of the delimiter
    int           n_lines;
    bit           redo;
    // a late delimiter lands after the hunt has already given up
    n_fill = (e.has_delim != 0) ? 1 : 1 + `BURST_HUNT_LIMIT;
    do begin
      payload.delete();
      aligned_q.delete();
      lines.delete();
      redo = 1'b0;
      for (int i = 0; i < e.len; i++) payload.push_back(random_payload());
      repeat (n_fill) aligned_q.push_back('0);
      aligned_q.push_back(`BURST_DELIMITER);
      foreach (payload[i]) aligned_q.push_back(payload[i]);
      aligned_q.push_back(`BURST_TAIL);
      aligned_q.push_back('0);  // fill behind the tail
      // line word j carries the low bits of aligned j, then the top of j+1
      for (int j = 0; j + 1 < aligned_q.size(); j++) begin
        pair = {aligned_q[j], aligned_q[j+1]} << e.offset;
        lines.push_back(pair[2*W-1 -: W]);
        // no false sop
        if (j >= n_fill && j <= n_fill + e.len && near_preamble(lines[j])) redo = 1'b1;
      end
    end while (redo);
    n_lines = (e.cut != 0) ? n_fill + e.cut + 1 : lines.size();
    line_q.delete();
    repeat (IDLE_WORDS) line_q.push_back({1'b1, word_t'(0)});
    for (int i = 0; i < e.n_pre; i++) begin
      line_q.push_back({1'b1, word_t'(`BURST_PREAMBLE) ^ error_mask(e.pre_err)});
    end
    for (int j = 0; j < n_lines; j++) line_q.push_back({1'b1, lines[j]});
    if (e.cut != 0) repeat (4) line_q.push_back({1'b0, word_t'(0)}); // receiver lost
    repeat (IDLE_WORDS) line_q.push_back({1'b1, word_t'(0)});
  endtask

  // ----------------------------------------------------------------------
  // drivers and waits
  // ----------------------------------------------------------------------

  function automatic logic ready_for(input int mode);
    logic [31:0] r;
    r = $random(seed);
    case (mode)
      1:       return r[0];
      2:       return 1'b0;
      default: return 1'b1;
    endcase
  endfunction

  task automatic drive(input logic active, input word_t data, input logic ready);
    @(posedge axis_aclk_gt_rx_usrclk);
    #2;
    rx_active     = active;
    rx_data       = data;
    m_axis_tready = ready;
  endtask

  task automatic wait_drain(input string name);
    int n;
    n = 0;
    @(posedge axis_aclk_gt_rx_usrclk);
    #2 m_axis_tready = 1'b1;   // release any back-pressure
    while (u_chk.pending() != 0 && n < DRAIN_LIMIT) begin
      @(posedge axis_aclk_gt_rx_usrclk);
      n++;
    end
    if (u_chk.pending() != 0) begin
      timeouts++;
      $display("test %s: timed out with %0d expected words never delivered",
               name, u_chk.pending());
    end
  endtask

  task automatic run_entry(input entry_t e);
    logic last;
    build_stream(e);
    u_chk.start_test(e.name);
    for (int i = 0; i < e.exp_words; i++) begin
      last = (i == e.len - 1) || (e.cut != 0 && i == e.cut - 1);
      u_chk.expect_word(payload[i], last);
    end
    foreach (line_q[i]) drive(line_q[i][W], line_q[i][W-1:0], ready_for(e.ready_mode));
    wait_drain(e.name);
    u_chk.end_test(e.exp_sop, e.exp_words, e.exp_ovf);
  endtask

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------

  initial begin
    arst_n        = 1'b0;
    rx_active     = 1'b0;
    rx_data       = '0;
    m_axis_tready = 1'b0;
    load_table();
    repeat (8) @(posedge axis_aclk_gt_rx_usrclk);
    #2 arst_n = 1'b1;
    u_chk.check_quiet("after_reset");
    for (int t = 0; t < NUM_TESTS && timeouts == 0; t++) run_entry(tbl[t]);
    if (timeouts == 0) begin
      @(posedge axis_aclk_gt_rx_usrclk);
      #2 arst_n = 1'b0;        // clears the sticky overflow too
      repeat (8) @(posedge axis_aclk_gt_rx_usrclk);
      #2 arst_n = 1'b1;
      u_chk.check_quiet("reset_again");
    end
    u_chk.report(timeouts);
    if (u_chk.data_errs == 0 && u_chk.count_errs == 0 && timeouts == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+hw
hw/burst_rx_pkg.sv
hw/burst_word_if.sv
hw/preamble_detector.sv
hw/delimiter_aligner.sv
hw/rx_stream_fifo.sv
hw/burst_rx_top.sv
tests/burst_rx_checker.sv
tests/tb_burst_rx.sv

//--- Makefile
# verilator build and run of the burst receive testbench

TOP := tb_burst_rx

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/100ps -Wno-fatal \
		-f sources.f --top-module $(TOP)

# the run passes only when the pass line shows up in the output
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^=== PASS ===$$'

clean:
	rm -rf obj_dir
